//--- stbuf_top.f
rtl/stbuf_pkg.sv
rtl/stbuf_drain_if.sv
rtl/stbuf_entry.sv
rtl/stbuf_entry_array.sv
rtl/stbuf_l1d_writer.sv
rtl/stbuf_load_merge.sv
rtl/stbuf_top.sv
test/tb_stbuf_top.sv

//--- Bender.yml
package:
  name: stbuf_top

sources:
  # Package and interface first, then the modules bottom-up
  - rtl/stbuf_pkg.sv
  - rtl/stbuf_drain_if.sv
  - rtl/stbuf_entry.sv
  - rtl/stbuf_entry_array.sv
  - rtl/stbuf_l1d_writer.sv
  - rtl/stbuf_load_merge.sv
  - rtl/stbuf_top.sv
  - target: simulation
    files:
      - test/tb_stbuf_top.sv

//--- test/tb_stbuf_top.sv
// Lines are written in full before they are loaded, since the array comes up undefined
`timescale 1ns/1ps

module tb_stbuf_top;

  localparam int ENTRIES      = 4;
  localparam int WR_CREDITS   = 2;
  localparam int RST_CYCLES   = 10;
  localparam int NROWS        = 23;
  localparam int DRAIN_CYCLES = 40;

  typedef enum logic [2:0] {OP_IDLE, OP_STORE, OP_FILL, OP_LOAD, OP_CRED, OP_MIX} op_e;
  typedef struct packed {
    op_e                   op;
    stbuf_pkg::line_idx_t  idx;
    stbuf_pkg::line_data_t data;
    stbuf_pkg::line_strb_t strb;
    logic [15:0]           rep;
  } row_t;

  logic                  i_clk;
  logic                  i_reset_n;
  logic                  i_st_valid;
  stbuf_pkg::line_idx_t  i_st_idx;
  stbuf_pkg::line_data_t i_st_data;
  stbuf_pkg::line_strb_t i_st_strb;
  logic                  o_st_credit;
  logic                  i_ld_valid;
  stbuf_pkg::line_idx_t  i_ld_idx;
  logic                  o_ld_valid;
  stbuf_pkg::line_data_t o_ld_data;

  stbuf_pkg::line_data_t model [64];
  stbuf_pkg::line_data_t exp_q [$];
  logic [31:0]           lfsr = 32'h5696_8afe;
  int                    credits = ENTRIES;
  int                    cycles = 0;
  int                    limit = 0;
  logic                  in_run = 1'b0;
  logic                  ld_prev = 1'b0;

  // op, idx, data, strb, repeat (idx steps by one per repeat)
  row_t tbl [NROWS] = '{
    '{OP_IDLE,  6'd0, 64'h0, 8'h00, 16'd5},
    '{OP_FILL,  6'd0, 64'h0, 8'hff, 16'd8},
    '{OP_IDLE,  6'd0, 64'h0, 8'h00, 16'd20},
    // Forwarding straight after the store
    '{OP_STORE, 6'd3, 64'h1111_2222_3333_4444, 8'h0f, 16'd1},
    '{OP_LOAD,  6'd3, 64'h0, 8'h00, 16'd1},
    // Back-to-back stores, the later ones to line 5 merge
    '{OP_STORE, 6'd1, 64'h0101_0101_0101_0101, 8'h81, 16'd2},
    '{OP_STORE, 6'd5, 64'h5555_aaaa_5555_aaaa, 8'h03, 16'd1},
    '{OP_STORE, 6'd5, 64'hbbbb_cccc_dddd_eeee, 8'h30, 16'd1},
    '{OP_STORE, 6'd5, 64'h7777_8888_9999_0000, 8'h06, 16'd1},
    '{OP_LOAD,  6'd5, 64'h0, 8'h00, 16'd1},
    '{OP_LOAD,  6'd0, 64'h0, 8'h00, 16'd8},
    // ENTRIES distinct lines, drained and read back from the array
    '{OP_FILL,  6'd0, 64'h0, 8'hff, 16'd4},
    '{OP_IDLE,  6'd0, 64'h0, 8'h00, 16'd20},
    '{OP_CRED,  6'd0, 64'h0, 8'h00, 16'd1},
    '{OP_LOAD,  6'd0, 64'h0, 8'h00, 16'd4},
    // Overlapping stores to one line across the drain
    '{OP_STORE, 6'd6, 64'hdead_beef_cafe_f00d, 8'h3c, 16'd1},
    '{OP_IDLE,  6'd0, 64'h0, 8'h00, 16'd1},
    '{OP_STORE, 6'd6, 64'h0123_4567_89ab_cdef, 8'h0f, 16'd1},
    '{OP_LOAD,  6'd6, 64'h0, 8'h00, 16'd1},
    '{OP_LOAD,  6'd6, 64'h0, 8'h00, 16'd1},
    '{OP_IDLE,  6'd0, 64'h0, 8'h00, 16'd1},
    '{OP_LOAD,  6'd6, 64'h0, 8'h00, 16'd1},
    '{OP_MIX,   6'd0, 64'h0, 8'h00, 16'd400}
  };

  stbuf_top #(.ENTRIES(ENTRIES), .WR_CREDITS(WR_CREDITS)) dut_i (.*);

  always #5 i_clk = ~i_clk;

  // ------------------------------------------------
  // Checks
  // ------------------------------------------------
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_line(input string name, input stbuf_pkg::line_data_t got,
                            input stbuf_pkg::line_data_t exp);
    if (got !== exp) begin
      stop_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_credits(input string name, input int got, input int exp);
    if (got != exp) begin
      stop_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // Galois LFSR, one step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v[k] = lfsr[0];
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
  endfunction

  // ------------------------------------------------
  // Drivers
  // ------------------------------------------------
  task automatic step_idle();
    @(posedge i_clk);
    i_st_valid <= 1'b0;
    i_ld_valid <= 1'b0;
  endtask

  task automatic send_store(input stbuf_pkg::line_idx_t idx, input stbuf_pkg::line_data_t data,
                            input stbuf_pkg::line_strb_t strb);
    while (credits == 0) begin
      step_idle();
    end
    @(posedge i_clk);
    i_st_valid <= 1'b1;
    i_st_idx   <= idx;
    i_st_data  <= data;
    i_st_strb  <= strb;
    i_ld_valid <= 1'b0;
    credits--;
    for (int b = 0; b < stbuf_pkg::LINE_B; b++) begin
      if (strb[b]) model[idx][b*8 +: 8] = data[b*8 +: 8];
    end
  endtask

  task automatic send_load(input stbuf_pkg::line_idx_t idx);
    @(posedge i_clk);
    i_ld_valid <= 1'b1;
    i_ld_idx   <= idx;
    i_st_valid <= 1'b0;
    exp_q.push_back(model[idx]);
  endtask

  task automatic apply_row(input row_t r);
    stbuf_pkg::line_idx_t  idx;
    stbuf_pkg::line_data_t data;
    stbuf_pkg::line_strb_t strb;
    for (int i = 0; i < int'(r.rep); i++) begin
      idx = stbuf_pkg::line_idx_t'(int'(r.idx) + i);
      case (r.op)
        OP_IDLE:  step_idle();
        OP_STORE: send_store(idx, r.data, r.strb);
        OP_FILL:  send_store(idx, rand_bits(64), r.strb);
        OP_LOAD:  send_load(idx);
        OP_CRED:  check_credits("credits", credits, ENTRIES);
        default: begin
          // Random mix over lines 0 to 7
          idx = stbuf_pkg::line_idx_t'(rand_bits(3));
          if (rand_bits(1) == 64'd1) begin
            data = rand_bits(64);
            strb = stbuf_pkg::line_strb_t'(rand_bits(8));
            if (strb == '0) strb = 8'h01;
            send_store(idx, data, strb);
          end else begin
            send_load(idx);
          end
        end
      endcase
    end
  endtask

  // ------------------------------------------------
  // Monitor on the falling edge, outputs settled
  // ------------------------------------------------
  always @(negedge i_clk) begin
    if (in_run) begin
      check_flag("o_ld_valid", o_ld_valid, ld_prev);
      if (o_ld_valid) begin
        check_line("o_ld_data", o_ld_data, exp_q.pop_front());
      end
      if (o_st_credit) begin
        if (credits >= ENTRIES) stop_run("store credit returned while all credits were held");
        credits++;
      end
      ld_prev = i_ld_valid;
    end
  end

  always @(posedge i_clk) begin
    cycles++;
    if (limit != 0 && cycles >= limit) begin
      stop_run("timeout: the run did not finish within the cycle limit");
    end
  end

  initial begin
    int drain_wait;
    i_clk      = 1'b0;
    i_reset_n  = 1'b0;
    i_st_valid = 1'b0;
    i_st_idx   = '0;
    i_st_data  = '0;
    i_st_strb  = '0;
    i_ld_valid = 1'b0;
    i_ld_idx   = '0;
    for (int l = 0; l < 64; l++) model[l] = 'x;
    limit = RST_CYCLES + 40;
    for (int r = 0; r < NROWS; r++) limit += 40 * int'(tbl[r].rep);
    repeat (RST_CYCLES) @(posedge i_clk);
    i_reset_n <= 1'b1;
    in_run = 1'b1;
    for (int r = 0; r < NROWS; r++) apply_row(tbl[r]);
    // Buffer drains and hands back its store credits
    drain_wait = 0;
    while ((exp_q.size() != 0 || credits != ENTRIES) && drain_wait < DRAIN_CYCLES) begin
      step_idle();
      drain_wait++;
    end
    // Let any queued credit return show up
    repeat (4) step_idle();
    check_credits("credits", credits, ENTRIES);
    $display("sim passed");
    $finish;
  end

endmodule

//--- rtl/stbuf_top.sv
// Store sender starts with ENTRIES credits; load data returns exactly one cycle after i_ld_valid
`timescale 1ns/1ps

module stbuf_top #(
  parameter int ENTRIES    = 4,
  parameter int WR_CREDITS = 2
) (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  // Store port
  input  logic                  i_st_valid,
  input  stbuf_pkg::line_idx_t  i_st_idx,
  input  stbuf_pkg::line_data_t i_st_data,
  input  stbuf_pkg::line_strb_t i_st_strb,
  output logic                  o_st_credit,
  // Load port
  input  logic                  i_ld_valid,
  input  stbuf_pkg::line_idx_t  i_ld_idx,
  output logic                  o_ld_valid,
  output stbuf_pkg::line_data_t o_ld_data
);

  stbuf_pkg::line_data_t w_fwd_data;
  stbuf_pkg::line_strb_t w_fwd_strb;
  stbuf_pkg::line_data_t w_rd_data;

  stbuf_drain_if drain_if ();

  stbuf_entry_array #(
    .ENTRIES    (ENTRIES),
    .WR_CREDITS (WR_CREDITS)
  ) u_entry_array (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_st_valid  (i_st_valid),
    .i_st_idx    (i_st_idx),
    .i_st_data   (i_st_data),
    .i_st_strb   (i_st_strb),
    .o_st_credit (o_st_credit),
    .i_ld_valid  (i_ld_valid),
    .i_ld_idx    (i_ld_idx),
    .o_fwd_data  (w_fwd_data),
    .o_fwd_strb  (w_fwd_strb),
    .drain       (drain_if.issuer)
  );

  // Array read shares the load index
  stbuf_l1d_writer #(
    .WR_CREDITS (WR_CREDITS)
  ) u_l1d_writer (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .drain     (drain_if.writer),
    .i_rd_idx  (i_ld_idx),
    .o_rd_data (w_rd_data)
  );

  stbuf_load_merge u_load_merge (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_ld_valid (i_ld_valid),
    .i_fwd_data (w_fwd_data),
    .i_fwd_strb (w_fwd_strb),
    .i_rd_data  (w_rd_data),
    .o_ld_valid (o_ld_valid),
    .o_ld_data  (o_ld_data)
  );

endmodule

//--- rtl/stbuf_load_merge.sv
// i_rd_data must come from a registered read launched with the same load; no stall on the load path
`timescale 1ns/1ps

module stbuf_load_merge (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_ld_valid,
  input  stbuf_pkg::line_data_t i_fwd_data,
  input  stbuf_pkg::line_strb_t i_fwd_strb,
  input  stbuf_pkg::line_data_t i_rd_data,
  output logic                  o_ld_valid,
  output stbuf_pkg::line_data_t o_ld_data
);

  logic                  r_ld_valid;
  stbuf_pkg::line_data_t r_fwd_data;
  stbuf_pkg::line_strb_t r_fwd_strb;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ld_valid <= 1'b0;
    end else begin
      r_ld_valid <= i_ld_valid;
    end
  end

  // Sampled on the same edge as the array read
  always_ff @(posedge i_clk) begin
    r_fwd_data <= i_fwd_data;
    r_fwd_strb <= i_fwd_strb;
  end

  // Buffered bytes override the array line
  always_comb begin
    for (int b = 0; b < stbuf_pkg::LINE_B; b++) begin
      o_ld_data[b*8 +: 8] = r_fwd_strb[b] ? r_fwd_data[b*8 +: 8] : i_rd_data[b*8 +: 8];
    end
  end

  assign o_ld_valid = r_ld_valid;

endmodule

//--- rtl/stbuf_l1d_writer.sv
// WR_CREDITS must be >= 2; array contents are undefined after power-up and reset does not clear them
`timescale 1ns/1ps

module stbuf_l1d_writer #(
  parameter int WR_CREDITS = 2
) (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  stbuf_drain_if.writer         drain,
  input  stbuf_pkg::line_idx_t  i_rd_idx,
  output stbuf_pkg::line_data_t o_rd_data
);

  localparam int LINES = 2 ** stbuf_pkg::IDX_W;

  logic                    r_s1_valid;
  stbuf_pkg::drain_req_t   r_s1_req;
  logic [WR_CREDITS-2:0]   r_crd_pipe;
  stbuf_pkg::line_data_t   r_mem [LINES];
  stbuf_pkg::line_data_t   w_wr_line;
  stbuf_pkg::line_data_t   r_rd_data;

  // ------------------------------------------------
  // Stage one, request register
  // ------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid <= 1'b0;
      r_crd_pipe <= '0;
    end else begin
      r_s1_valid <= drain.req_valid;
      // Credit trails the write so the round trip spans WR_CREDITS cycles
      r_crd_pipe <= (r_crd_pipe << 1) | (WR_CREDITS-1)'(r_s1_valid);
    end
  end

  always_ff @(posedge i_clk) begin
    if (drain.req_valid) begin
      r_s1_req <= drain.req;
    end
  end

  // Write lands on the edge that ends stage one
  assign drain.done   = r_s1_valid;
  assign drain.credit = r_crd_pipe[WR_CREDITS-2];

  // ------------------------------------------------
  // Stage two, byte-enabled array write
  // ------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (r_s1_valid) begin
      for (int b = 0; b < stbuf_pkg::LINE_B; b++) begin
        if (r_s1_req.strb[b]) begin
          r_mem[r_s1_req.idx][b*8 +: 8] <= r_s1_req.data[b*8 +: 8];
        end
      end
    end
  end

  // Line as it will look after this cycle's write
  always_comb begin
    w_wr_line = r_mem[r_s1_req.idx];
    for (int b = 0; b < stbuf_pkg::LINE_B; b++) begin
      if (r_s1_req.strb[b]) begin
        w_wr_line[b*8 +: 8] = r_s1_req.data[b*8 +: 8];
      end
    end
  end

  // ------------------------------------------------
  // Read port, write-first
  // ------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (r_s1_valid && (r_s1_req.idx == i_rd_idx)) begin
      r_rd_data <= w_wr_line;
    end else begin
      r_rd_data <= r_mem[i_rd_idx];
    end
  end

  assign o_rd_data = r_rd_data;

endmodule

//--- rtl/stbuf_entry_array.sv
// ENTRIES must be a power of two >= 2; the store sender must never exceed its ENTRIES credits
`timescale 1ns/1ps

module stbuf_entry_array #(
  parameter int ENTRIES    = 4,
  parameter int WR_CREDITS = 2
) (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_st_valid,
  input  stbuf_pkg::line_idx_t  i_st_idx,
  input  stbuf_pkg::line_data_t i_st_data,
  input  stbuf_pkg::line_strb_t i_st_strb,
  output logic                  o_st_credit,
  input  logic                  i_ld_valid,
  input  stbuf_pkg::line_idx_t  i_ld_idx,
  output stbuf_pkg::line_data_t o_fwd_data,
  output stbuf_pkg::line_strb_t o_fwd_strb,
  stbuf_drain_if.issuer         drain
);

  localparam int PTR_W = $clog2(ENTRIES);
  localparam int CRD_W = $clog2(WR_CREDITS + 1);
  localparam int RET_W = $clog2(ENTRIES) + 2;

  stbuf_pkg::stbuf_entry_t w_entries [ENTRIES];
  stbuf_pkg::stbuf_entry_t w_init;
  stbuf_pkg::stbuf_entry_t w_iss_entry;
  logic [ENTRIES-1:0]      w_merge;
  logic [ENTRIES-1:0]      w_load;
  logic [ENTRIES-1:0]      w_issue_oh;
  logic [ENTRIES-1:0]      w_free_oh;
  logic                    w_alloc;
  logic                    w_issue;
  logic [PTR_W-1:0]        r_in_ptr;
  logic [PTR_W-1:0]        r_iss_ptr;
  logic [PTR_W-1:0]        r_out_ptr;
  logic [CRD_W-1:0]        r_wr_credits;
  logic [RET_W-1:0]        r_ret_pend;
  logic [RET_W-1:0]        w_ret_total;

  assign w_init = '{valid: 1'b1, issued: 1'b0, idx: i_st_idx, data: i_st_data, strb: i_st_strb};
  assign w_alloc = i_st_valid & ~(|w_merge);

  // Oldest unissued entry goes out when a write credit is left
  assign w_iss_entry = w_entries[r_iss_ptr];
  assign w_issue     = w_iss_entry.valid & ~w_iss_entry.issued & (r_wr_credits != '0);

  assign drain.req_valid = w_issue;
  assign drain.req       = '{idx: w_iss_entry.idx, data: w_iss_entry.data, strb: w_iss_entry.strb};

  for (genvar e = 0; e < ENTRIES; e++) begin : g_entry
    assign w_issue_oh[e] = w_issue & (r_iss_ptr == PTR_W'(e));
    assign w_free_oh[e]  = drain.done & (r_out_ptr == PTR_W'(e));
    assign w_load[e]     = w_alloc & (r_in_ptr == PTR_W'(e));
    // An entry leaving this cycle takes no merge, the store allocates instead
    assign w_merge[e]    = i_st_valid & w_entries[e].valid & ~w_entries[e].issued &
                           (w_entries[e].idx == i_st_idx) & ~w_issue_oh[e];

    stbuf_entry u_entry (
      .i_clk     (i_clk),
      .i_reset_n (i_reset_n),
      .i_load    (w_load[e]),
      .i_init    (w_init),
      .i_merge   (w_merge[e]),
      .i_st_data (i_st_data),
      .i_st_strb (i_st_strb),
      .i_issue   (w_issue_oh[e]),
      .i_free    (w_free_oh[e]),
      .o_entry   (w_entries[e])
    );
  end

  // Merge and free in one cycle give two returns, queued here
  assign w_ret_total = r_ret_pend + RET_W'(|w_merge) + RET_W'(drain.done);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_in_ptr     <= '0;
      r_iss_ptr    <= '0;
      r_out_ptr    <= '0;
      r_wr_credits <= CRD_W'(WR_CREDITS);
      r_ret_pend   <= '0;
      o_st_credit  <= 1'b0;
    end else begin
      if (w_alloc) r_in_ptr <= r_in_ptr + PTR_W'(1);
      if (w_issue) r_iss_ptr <= r_iss_ptr + PTR_W'(1);
      if (drain.done) r_out_ptr <= r_out_ptr + PTR_W'(1);
      r_wr_credits <= r_wr_credits - CRD_W'(w_issue) + CRD_W'(drain.credit);
      o_st_credit  <= (w_ret_total != '0);
      r_ret_pend   <= (w_ret_total != '0) ? w_ret_total - RET_W'(1) : '0;
    end
  end

  // ------------------------------------------------
  // Load forwarding, youngest entry per byte
  // ------------------------------------------------
  always_comb begin : fwd_walk
    logic [PTR_W-1:0] pos;
    o_fwd_data = '0;
    o_fwd_strb = '0;
    for (int k = 0; k < ENTRIES; k++) begin
      pos = r_out_ptr + PTR_W'(k);
      for (int b = 0; b < stbuf_pkg::LINE_B; b++) begin
        if (i_ld_valid && w_entries[pos].valid && (w_entries[pos].idx == i_ld_idx) &&
            w_entries[pos].strb[b]) begin
          o_fwd_data[b*8 +: 8] = w_entries[pos].data[b*8 +: 8];
          o_fwd_strb[b]        = 1'b1;
        end
      end
    end
  end

endmodule

//--- rtl/stbuf_entry.sv
// i_load and i_merge must not both be set; merges are only legal while the entry is unissued
`timescale 1ns/1ps

module stbuf_entry (
  input  logic                    i_clk,
  input  logic                    i_reset_n,
  input  logic                    i_load,
  input  stbuf_pkg::stbuf_entry_t i_init,
  input  logic                    i_merge,
  input  stbuf_pkg::line_data_t   i_st_data,
  input  stbuf_pkg::line_strb_t   i_st_strb,
  input  logic                    i_issue,
  input  logic                    i_free,
  output stbuf_pkg::stbuf_entry_t o_entry
);

  logic                  r_valid;
  logic                  r_issued;
  stbuf_pkg::line_idx_t  r_idx;
  stbuf_pkg::line_data_t r_data;
  stbuf_pkg::line_strb_t r_strb;

  // ------------------------------------------------
  // Control state
  // ------------------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid  <= 1'b0;
      r_issued <= 1'b0;
    end else if (i_load) begin
      r_valid  <= 1'b1;
      r_issued <= i_init.issued;
    end else begin
      if (i_issue) begin
        r_issued <= 1'b1;
      end
      if (i_free) begin
        r_valid  <= 1'b0;
        r_issued <= 1'b0;
      end
    end
  end

  // ------------------------------------------------
  // Payload with byte-wise merge
  // ------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_load) begin
      r_idx  <= i_init.idx;
      r_data <= i_init.data;
      r_strb <= i_init.strb;
    end else if (i_merge) begin
      // Younger store wins on overlapping lanes
      for (int b = 0; b < stbuf_pkg::LINE_B; b++) begin
        if (i_st_strb[b]) begin
          r_data[b*8 +: 8] <= i_st_data[b*8 +: 8];
        end
      end
      r_strb <= r_strb | i_st_strb;
    end
  end

  assign o_entry = '{
    valid:  r_valid,
    issued: r_issued,
    idx:    r_idx,
    data:   r_data,
    strb:   r_strb
  };

endmodule

//--- rtl/stbuf_drain_if.sv
// No valid/ready handshake; the issuer must hold a write credit for every request it sends
`timescale 1ns/1ps

interface stbuf_drain_if;

  // Request from the buffer, one cycle wide
  logic                   req_valid;
  stbuf_pkg::drain_req_t  req;

  // Credit comes back as the request leaves stage one
  logic                   credit;
  // Bytes written, completes in issue order
  logic                   done;

  modport issuer (
    output req_valid,
    output req,
    input  credit,
    input  done
  );

  modport writer (
    input  req_valid,
    input  req,
    output credit,
    output done
  );

endinterface

//--- rtl/stbuf_pkg.sv
// Store width equals line width (8 bytes); 64 direct-mapped lines with no tags, every access hits

package stbuf_pkg;

  // ------------------------------------------------
  // Geometry
  // ------------------------------------------------
  localparam int LINE_B = 8;
  localparam int LINE_W = LINE_B * 8;
  localparam int IDX_W  = 6;

  typedef logic [IDX_W-1:0]  line_idx_t;
  typedef logic [LINE_W-1:0] line_data_t;
  typedef logic [LINE_B-1:0] line_strb_t;

  // ------------------------------------------------
  // Buffer entry
  // ------------------------------------------------
  // issued is set once the entry has gone to the write stage,
  // after which it no longer accepts merges
  typedef struct packed {
    logic       valid;
    logic       issued;
    line_idx_t  idx;
    line_data_t data;
    line_strb_t strb;
  } stbuf_entry_t;

  // ------------------------------------------------
  // Drain request to the write stage
  // ------------------------------------------------
  // Bytes sit in their lanes, strb selects the ones to write
  typedef struct packed {
    line_idx_t  idx;
    line_data_t data;
    line_strb_t strb;
  } drain_req_t;

endpackage
